// File: Makefile
SIM := obj_dir/Vtb_sdram_ctrl

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): filelist.f hw/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module tb_sdram_ctrl -o Vtb_sdram_ctrl

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: filelist.f
hw/sdram_pkg.sv
hw/sdram_timer.sv
hw/sdram_bus_port.sv
hw/sdram_pin_reg.sv
hw/sdram_fsm.sv
hw/sdram_ctrl_top.sv
tb/sdram_model.sv
tb/tb_sdram_ctrl.sv

// File: hw/sdram_bus_port.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_bus_port #(
    parameter int AW          = 24,
    parameter int DW          = 16,
    parameter int CAS_LATENCY = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            bus_read,
    input  logic            bus_write,
    input  logic [AW-1:0]   bus_addr,
    input  logic [DW-1:0]   bus_wdata,
    input  logic [DW/8-1:0] bus_byteenable,
    output logic            bus_ready,
    output logic            bus_rvalid,
    output logic [DW-1:0]   bus_rdata,
    input  logic            int_ready,      // From FSM, one cycle ahead of bus_ready
    input  logic            read_issue,     // READ decided this cycle
    input  logic [DW-1:0]   dq_in,
    output logic            req_take,
    output logic            pend_read,
    output logic            pend_write,
    output logic [AW-1:0]   cap_addr,
    output logic [DW-1:0]   cap_wdata,
    output logic [DW/8-1:0] cap_be
);

    // READ decision to dq sample: pin register, CL, model output edge
    localparam int LAT   = CAS_LATENCY + 1;
    localparam int LAT_W = $clog2(LAT + 1);

    logic [LAT_W-1:0] lat_cnt;
    logic             wait_rd;      // Read data still on its way
    logic             rvalid_int;

    // ------------------------------
    // Request capture
    // ------------------------------
    assign req_take = (bus_read | bus_write) & bus_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_read  <= 1'b0;
            pend_write <= 1'b0;
        end else if (req_take) begin
            pend_read  <= bus_read;
            pend_write <= bus_write;
        end else if (int_ready) begin   // Access or refresh finished
            pend_read  <= 1'b0;
            pend_write <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_take) begin
            cap_addr  <= bus_addr;
            cap_wdata <= bus_wdata;
            cap_be    <= bus_byteenable;
        end
    end

    // ------------------------------
    // Read latency
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lat_cnt <= '0;
            wait_rd <= 1'b0;
        end else if (read_issue) begin
            lat_cnt <= LAT_W'(LAT);
            wait_rd <= 1'b1;
        end else if (lat_cnt != '0) begin
            lat_cnt <= lat_cnt - 1'b1;
        end else begin
            wait_rd <= 1'b0;            // Data sampled this edge
        end
    end

    assign rvalid_int = wait_rd & (lat_cnt == '0);

    // Bus outputs one cycle late
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_ready  <= 1'b0;
            bus_rvalid <= 1'b0;
        end else begin
            bus_ready  <= int_ready;
            bus_rvalid <= rvalid_int;
        end
    end

    always_ff @(posedge clk) begin
        if (rvalid_int) bus_rdata <= dq_in;
    end

    // Each rvalid pulse traces back to one READ decision in the FSM
    a_rvalid_from_read: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus_rvalid) |-> $past(read_issue, LAT + 2));

endmodule

`default_nettype wire

// File: hw/sdram_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_ctrl_top
    import sdram_pkg::*;
#(
    parameter int CLK_MHZ        = 100,
    parameter int AW             = 24,      // Byte address width
    parameter int DW             = 16,
    parameter int RAW            = 12,
    parameter int CAW            = 9,
    parameter int CAS_LATENCY    = 2,       // 2 or 3
    parameter int INIT_CYCLES    = 10000,   // Power-up deselect wait
    parameter int REFRESH_CYCLES = 1500     // Refresh interval
) (
    input  logic            clk,
    input  logic            rst_n,
    // System bus
    input  logic            bus_read,
    input  logic            bus_write,
    input  logic [AW-1:0]   bus_addr,
    input  logic [DW-1:0]   bus_wdata,
    input  logic [DW/8-1:0] bus_byteenable,
    output logic            bus_ready,
    output logic            bus_rvalid,
    output logic [DW-1:0]   bus_rdata,
    // SDRAM pins
    output logic            sdram_cke,
    output logic            sdram_cs_n,
    output logic            sdram_ras_n,
    output logic            sdram_cas_n,
    output logic            sdram_we_n,
    output logic [RAW-1:0]  sdram_addr,
    output logic [1:0]      sdram_ba,
    output logic [DW/8-1:0] sdram_dqm,
    inout  wire  [DW-1:0]   sdram_dq
);

    // Device timing in clock cycles
    localparam int C_RP  = ceil_div(T_RP_NS,  CLK_MHZ);
    localparam int C_RFC = ceil_div(T_RFC_NS, CLK_MHZ);
    localparam int C_RCD = ceil_div(T_RCD_NS, CLK_MHZ);
    localparam int C_WR  = ceil_div(T_WR_NS,  CLK_MHZ);
    localparam int BW    = $clog2(DW / 8);  // Byte select bits

    logic            req_take, pend_read, pend_write;
    logic            int_ready, read_issue;
    logic [AW-1:0]   cap_addr;
    logic [DW-1:0]   cap_wdata;
    logic [DW/8-1:0] cap_be;
    logic [1:0]      bank;
    logic [RAW-1:0]  row;
    logic [CAW-1:0]  col;
    logic            ir_load_init, ir_load_refresh, ir_zero;
    logic            cmd_load, cmd_done;
    sdram_cmd_t      cmd_kind, nxt_cmd;
    logic [RAW-1:0]  nxt_addr;
    logic [1:0]      nxt_ba;
    logic [DW/8-1:0] nxt_dqm;
    logic [DW-1:0]   nxt_dq, dq_in;
    logic            nxt_dq_en;

    // Word address maps to {bank, row, col}
    assign {bank, row, col} = cap_addr[AW-1:BW];

    sdram_bus_port #(.AW(AW), .DW(DW), .CAS_LATENCY(CAS_LATENCY)) u_bus_port (
        .clk, .rst_n, .bus_read, .bus_write, .bus_addr, .bus_wdata, .bus_byteenable,
        .bus_ready, .bus_rvalid, .bus_rdata, .int_ready, .read_issue, .dq_in,
        .req_take, .pend_read, .pend_write, .cap_addr, .cap_wdata, .cap_be
    );

    sdram_fsm #(.CAW(CAW), .RAW(RAW), .DW(DW), .CAS_LATENCY(CAS_LATENCY)) u_fsm (
        .clk, .rst_n, .pend_read, .pend_write, .req_take, .bank, .row, .col,
        .wdata(cap_wdata), .byteenable(cap_be), .ir_zero, .cmd_done,
        .ir_load_init, .ir_load_refresh, .cmd_load, .cmd_kind, .read_issue, .int_ready,
        .nxt_cmd, .nxt_addr, .nxt_ba, .nxt_dqm, .nxt_dq, .nxt_dq_en
    );

    sdram_timer #(
        .INIT_CYCLES(INIT_CYCLES), .REFRESH_CYCLES(REFRESH_CYCLES),
        .C_RP(C_RP), .C_RFC(C_RFC), .C_RCD(C_RCD), .C_WR(C_WR),
        .CAS_LATENCY(CAS_LATENCY)
    ) u_timer (
        .clk, .rst_n, .ir_load_init, .ir_load_refresh, .cmd_load, .cmd_kind,
        .ir_zero, .cmd_done
    );

    sdram_pin_reg #(.RAW(RAW), .DW(DW)) u_pin_reg (
        .clk, .rst_n, .nxt_cmd, .nxt_addr, .nxt_ba, .nxt_dqm, .nxt_dq, .nxt_dq_en,
        .sdram_cke, .sdram_cs_n, .sdram_ras_n, .sdram_cas_n, .sdram_we_n,
        .sdram_addr, .sdram_ba, .sdram_dqm, .dq_in, .sdram_dq
    );

endmodule

`default_nettype wire

// File: hw/sdram_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_fsm
    import sdram_pkg::*;
#(
    parameter int CAW         = 9,
    parameter int RAW         = 12,
    parameter int DW          = 16,
    parameter int CAS_LATENCY = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pend_read,
    input  logic            pend_write,
    input  logic            req_take,       // Request taken this cycle
    input  logic [1:0]      bank,
    input  logic [RAW-1:0]  row,
    input  logic [CAW-1:0]  col,
    input  logic [DW-1:0]   wdata,
    input  logic [DW/8-1:0] byteenable,
    input  logic            ir_zero,
    input  logic            cmd_done,
    output logic            ir_load_init,
    output logic            ir_load_refresh,
    output logic            cmd_load,
    output sdram_cmd_t      cmd_kind,
    output logic            read_issue,
    output logic            int_ready,
    output sdram_cmd_t      nxt_cmd,
    output logic [RAW-1:0]  nxt_addr,
    output logic [1:0]      nxt_ba,
    output logic [DW/8-1:0] nxt_dqm,
    output logic [DW-1:0]   nxt_dq,
    output logic            nxt_dq_en
);

    // Mode register: BL1, sequential, CL from parameter
    localparam logic [2:0] MR_BL = 3'b000;
    localparam logic       MR_BT = 1'b0;
    localparam logic [2:0] MR_CL = 3'(CAS_LATENCY);
    localparam logic       MR_WB = 1'b0;    // BL1 already gives single writes
    localparam logic [RAW-1:0] MODE_WORD = RAW'({MR_WB, 2'b00, MR_CL, MR_BT, MR_BL});

    ctrl_state_t state, state_n;
    init_state_t init_state, init_n;
    logic        pend;

    assign pend = pend_read | pend_write;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_RESET;
            init_state <= INIT_IDLE;
        end else begin
            state      <= state_n;
            init_state <= init_n;
        end
    end

    // ------------------------------
    // Next state and command decode
    // ------------------------------
    always_comb begin
        state_n         = state;
        init_n          = init_state;
        nxt_cmd         = CMD_NOP;      // NOP fills every spacing gap
        nxt_addr        = '0;
        nxt_ba          = '0;
        nxt_dqm         = '0;
        nxt_dq          = '0;
        nxt_dq_en       = 1'b0;
        int_ready       = 1'b0;
        ir_load_init    = 1'b0;
        ir_load_refresh = 1'b0;
        case (state)
            ST_RESET: begin
                nxt_cmd      = CMD_DESL;
                ir_load_init = 1'b1;    // Start deselect wait
                state_n      = ST_INIT;
                init_n       = INIT_WAIT;
            end
            ST_INIT: begin
                case (init_state)
                    INIT_WAIT: begin
                        nxt_cmd = CMD_DESL;
                        if (ir_zero) begin
                            nxt_cmd      = CMD_PRECHARGE;
                            nxt_addr[10] = 1'b1;    // All banks
                            init_n       = INIT_PRECHARGE;
                        end
                    end
                    INIT_PRECHARGE: if (cmd_done) begin
                        nxt_cmd = CMD_REFRESH;
                        init_n  = INIT_AUTO_REF0;
                    end
                    INIT_AUTO_REF0: if (cmd_done) begin
                        nxt_cmd = CMD_REFRESH;
                        init_n  = INIT_AUTO_REF1;
                    end
                    INIT_AUTO_REF1: if (cmd_done) begin
                        nxt_cmd  = CMD_LMR;
                        nxt_addr = MODE_WORD;
                        init_n   = INIT_SET_MODE_REG;
                    end
                    INIT_SET_MODE_REG: if (cmd_done) init_n = INIT_DONE;   // tMRD over
                    INIT_DONE: begin
                        state_n         = ST_IDLE;
                        ir_load_refresh = 1'b1;     // First refresh interval
                    end
                    default: nxt_cmd = CMD_DESL;
                endcase
            end
            ST_IDLE: begin
                int_ready = ~req_take;          // Drop ready on a take
                if (ir_zero) begin              // Refresh wins over a request
                    nxt_cmd         = CMD_REFRESH;
                    ir_load_refresh = 1'b1;
                    int_ready       = 1'b0;
                    state_n         = ST_AUTO_REFRESH;
                end else if (pend) begin
                    nxt_cmd   = CMD_ACTIVE;
                    nxt_ba    = bank;
                    nxt_addr  = row;
                    int_ready = 1'b0;
                    state_n   = ST_ROW_ACTIVE;
                end
            end
            ST_ROW_ACTIVE: if (cmd_done) begin
                nxt_ba                = bank;
                nxt_addr[CAW-1:0]     = col;
                nxt_addr[10]          = 1'b1;   // Auto-precharge
                nxt_dqm               = ~byteenable;
                if (pend_write) begin
                    nxt_cmd   = CMD_WRITE;
                    nxt_dq    = wdata;
                    nxt_dq_en = 1'b1;
                    state_n   = ST_WRITE_A;
                end else if (pend_read) begin
                    nxt_cmd = CMD_READ;
                    state_n = ST_READ_A;
                end
            end
            ST_WRITE_A, ST_READ_A: if (cmd_done) begin
                int_ready = 1'b1;               // Access done, bank precharged
                state_n   = ST_IDLE;
            end
            ST_AUTO_REFRESH: if (cmd_done) begin
                if (pend) begin                 // Request arrived during refresh
                    nxt_cmd  = CMD_ACTIVE;
                    nxt_ba   = bank;
                    nxt_addr = row;
                    state_n  = ST_ROW_ACTIVE;
                end else begin
                    int_ready = 1'b1;
                    state_n   = ST_IDLE;
                end
            end
            default: state_n = ST_RESET;
        endcase
    end

    assign cmd_load   = (nxt_cmd != CMD_NOP) && (nxt_cmd != CMD_DESL);
    assign cmd_kind   = nxt_cmd;
    assign read_issue = (nxt_cmd == CMD_READ);

    a_state_legal: assert property (@(posedge clk) disable iff (!rst_n)
        state inside {ST_RESET, ST_INIT, ST_IDLE, ST_ROW_ACTIVE,
                      ST_WRITE_A, ST_READ_A, ST_AUTO_REFRESH});

    // Column commands only once tRCD has run out in the timer
    a_col_after_rcd: assert property (@(posedge clk) disable iff (!rst_n)
        (nxt_cmd inside {CMD_READ, CMD_WRITE}) |-> (state == ST_ROW_ACTIVE && cmd_done));

endmodule

`default_nettype wire

// File: hw/sdram_pin_reg.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_pin_reg
    import sdram_pkg::*;
#(
    parameter int RAW = 12,
    parameter int DW  = 16
) (
    input  logic            clk,
    input  logic            rst_n,
    input  sdram_cmd_t      nxt_cmd,
    input  logic [RAW-1:0]  nxt_addr,
    input  logic [1:0]      nxt_ba,
    input  logic [DW/8-1:0] nxt_dqm,
    input  logic [DW-1:0]   nxt_dq,
    input  logic            nxt_dq_en,
    output logic            sdram_cke,
    output logic            sdram_cs_n,
    output logic            sdram_ras_n,
    output logic            sdram_cas_n,
    output logic            sdram_we_n,
    output logic [RAW-1:0]  sdram_addr,
    output logic [1:0]      sdram_ba,
    output logic [DW/8-1:0] sdram_dqm,
    output logic [DW-1:0]   dq_in,
    inout  wire  [DW-1:0]   sdram_dq
);

    logic [DW-1:0] dq_out;
    logic          dq_en;           // Drive dq in the WRITE cycle only

    // ------------------------------
    // Control pins
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sdram_cke <= 1'b0;      // Clock held off in reset
            {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} <= CMD_DESL;
            dq_en     <= 1'b0;
        end else begin
            sdram_cke <= 1'b1;
            {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n} <= nxt_cmd;
            dq_en     <= nxt_dq_en;
        end
    end

    // Address, mask and data
    always_ff @(posedge clk) begin
        sdram_addr <= nxt_addr;
        sdram_ba   <= nxt_ba;
        sdram_dqm  <= nxt_dqm;
        dq_out     <= nxt_dq;
    end

    assign sdram_dq = dq_en ? dq_out : {DW{1'bz}};
    assign dq_in    = sdram_dq;     // Sampled by the bus port

endmodule

`default_nettype wire

// File: hw/sdram_pkg.sv
`default_nettype none

package sdram_pkg;

    // ------------------------------
    // SDRAM commands
    // ------------------------------
    // Bit order is {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_DESL      = 4'b1111,    // Device deselect
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,    // Open a row
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001,    // Auto refresh, cke high
        CMD_LMR       = 4'b0000     // Load mode register
    } sdram_cmd_t;

    // ------------------------------
    // Controller states
    // ------------------------------
    typedef enum logic [2:0] {
        ST_RESET,
        ST_INIT,            // Power-up sequence running
        ST_IDLE,            // All banks precharged
        ST_ROW_ACTIVE,      // Row open, waiting on tRCD
        ST_WRITE_A,         // Write with auto-precharge
        ST_READ_A,          // Read with auto-precharge
        ST_AUTO_REFRESH
    } ctrl_state_t;

    typedef enum logic [2:0] {
        INIT_IDLE,
        INIT_WAIT,          // Deselect wait after power-up
        INIT_PRECHARGE,
        INIT_AUTO_REF0,
        INIT_AUTO_REF1,
        INIT_SET_MODE_REG,
        INIT_DONE
    } init_state_t;

    localparam int CMD_CNT_W = 4;   // Longest spacing is tWR+tRP or CL+tRP

    // Default device timing, ns
    localparam int T_RP_NS  = 18;   // Precharge period
    localparam int T_RFC_NS = 60;   // Auto refresh period
    localparam int T_RCD_NS = 18;   // ACTIVE to READ/WRITE
    localparam int T_WR_NS  = 20;   // Write recovery
    localparam int C_MRD    = 3;    // LMR to next command, cycles

    // ns at a given clock in MHz, rounded up to whole cycles
    function automatic int ceil_div(input int ns, input int mhz);
        return (ns * mhz + 999) / 1000;
    endfunction

endpackage

`default_nettype wire

// File: hw/sdram_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_timer
    import sdram_pkg::*;
#(
    parameter int INIT_CYCLES    = 10000,
    parameter int REFRESH_CYCLES = 1500,
    parameter int C_RP           = 2,
    parameter int C_RFC          = 6,
    parameter int C_RCD          = 2,
    parameter int C_WR           = 2,
    parameter int CAS_LATENCY    = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ir_load_init,
    input  logic       ir_load_refresh,
    input  logic       cmd_load,
    input  sdram_cmd_t cmd_kind,
    output logic       ir_zero,
    output logic       cmd_done
);

    // Shared counter must also hold the refresh interval
    localparam int IR_MAX = (INIT_CYCLES > REFRESH_CYCLES) ? INIT_CYCLES : REFRESH_CYCLES;
    localparam int IR_W   = $clog2(IR_MAX + 1);

    // Count reaches zero when the next command may go out
    localparam logic [CMD_CNT_W-1:0] CNT_RP  = CMD_CNT_W'(C_RP - 1);
    localparam logic [CMD_CNT_W-1:0] CNT_RFC = CMD_CNT_W'(C_RFC - 1);
    localparam logic [CMD_CNT_W-1:0] CNT_MRD = CMD_CNT_W'(C_MRD - 1);
    localparam logic [CMD_CNT_W-1:0] CNT_RCD = CMD_CNT_W'(C_RCD - 1);
    localparam logic [CMD_CNT_W-1:0] CNT_WR  = CMD_CNT_W'(C_WR + C_RP - 1);         // Single write
    localparam logic [CMD_CNT_W-1:0] CNT_RD  = CMD_CNT_W'(CAS_LATENCY + C_RP - 1);  // Single read

    logic [IR_W-1:0]      ir_cnt;
    logic [CMD_CNT_W-1:0] cmd_cnt;

    // ------------------------------
    // Init wait / refresh interval
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ir_cnt <= '0;
        end else if (ir_load_init) begin
            ir_cnt <= IR_W'(INIT_CYCLES - 1);     // Counts DESL cycles on the pins
        end else if (ir_load_refresh) begin
            ir_cnt <= IR_W'(REFRESH_CYCLES);
        end else if (ir_cnt != '0) begin
            ir_cnt <= ir_cnt - 1'b1;
        end
    end

    assign ir_zero = (ir_cnt == '0);

    // ------------------------------
    // Command spacing
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmd_cnt <= '0;
        end else if (cmd_load) begin
            case (cmd_kind)
                CMD_PRECHARGE: cmd_cnt <= CNT_RP;
                CMD_REFRESH:   cmd_cnt <= CNT_RFC;
                CMD_LMR:       cmd_cnt <= CNT_MRD;
                CMD_ACTIVE:    cmd_cnt <= CNT_RCD;
                CMD_WRITE:     cmd_cnt <= CNT_WR;   // Includes auto-precharge
                CMD_READ:      cmd_cnt <= CNT_RD;
                default:       cmd_cnt <= '0;
            endcase
        end else if (cmd_cnt != '0) begin
            cmd_cnt <= cmd_cnt - 1'b1;
        end
    end

    assign cmd_done = (cmd_cnt == '0);

    // FSM must never cut a spacing short
    a_load_when_done: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_load |-> (cmd_cnt == '0));

endmodule

`default_nettype wire

// File: tb/sdram_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_model
    import sdram_pkg::*;
#(
    parameter int RAW         = 12,
    parameter int CAW         = 9,
    parameter int DW          = 16,
    parameter int CAS_LATENCY = 2
) (
    input  logic            clk,
    input  logic            cke,
    input  logic            cs_n,
    input  logic            ras_n,
    input  logic            cas_n,
    input  logic            we_n,
    input  logic [RAW-1:0]  addr,
    input  logic [1:0]      ba,
    input  logic [DW/8-1:0] dqm,
    inout  wire  [DW-1:0]   dq
);

    logic [DW-1:0]  mem [int];          // Sparse word store, key {ba, row, col}
    logic [RAW-1:0] open_row [4];       // Row opened per bank
    logic [3:0]     cmd;
    logic [DW-1:0]  rd_word;            // Word fetched at READ
    logic [DW-1:0]  drv_data;
    logic           drv_en;
    logic [DW-1:0]  merged;
    int             rd_cnt;

    assign cmd = {cs_n, ras_n, cas_n, we_n};
    assign dq  = drv_en ? drv_data : {DW{1'bz}};

    function automatic int key_of(input logic [1:0] b, input logic [RAW-1:0] r,
                                  input logic [CAW-1:0] c);
        return int'({b, r, c});
    endfunction

    // Unwritten words read back a pattern built from the whole address
    function automatic logic [DW-1:0] word_at(input int k);
        if (mem.exists(k)) return mem[k];
        return DW'(k ^ (k >> 7) ^ 32'h5a5a);
    endfunction

    initial begin
        drv_en = 1'b0;
        rd_cnt = 0;
    end

    // ------------------------------
    // Command decode
    // ------------------------------
    always @(posedge clk) begin
        drv_en <= 1'b0;                 // dq held one cycle only
        if (rd_cnt == 1) begin          // CL edges after READ
            drv_en   <= 1'b1;
            drv_data <= rd_word;
        end
        if (rd_cnt != 0) rd_cnt <= rd_cnt - 1;
        if (cke && cmd == CMD_ACTIVE) open_row[ba] <= addr;
        if (cke && cmd == CMD_READ) begin
            rd_word <= word_at(key_of(ba, open_row[ba], addr[CAW-1:0]));
            rd_cnt  <= CAS_LATENCY;
        end
        if (cke && cmd == CMD_WRITE) begin
            merged = word_at(key_of(ba, open_row[ba], addr[CAW-1:0]));
            for (int b = 0; b < DW/8; b++) begin
                if (!dqm[b]) merged[b*8 +: 8] = dq[b*8 +: 8];   // Masked bytes kept
            end
            mem[key_of(ba, open_row[ba], addr[CAW-1:0])] = merged;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_sdram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdram_ctrl
    import sdram_pkg::*;
;

    localparam int CL      = 2;
    localparam int INIT_C  = 20;
    localparam int REF_C   = 60;
    localparam int MHZ     = 25;
    localparam int C_RP    = 1;     // 18 ns fits in one 40 ns cycle
    localparam int C_RFC   = 2;     // 60 ns
    localparam int C_RCD   = 1;     // 18 ns
    localparam int C_WR    = 1;     // 20 ns
    localparam int ACC_LEN = C_RCD + CL + C_RP + C_WR + 4;      // One access, worst case
    localparam int BUDGET  = 4 * INIT_C + 12 * REF_C;           // Cycles per test
    localparam int LIMIT   = 2000;                              // Per wait loop

    logic        clk = 1'b0;
    logic        rst_n, bus_read, bus_write;
    logic [23:0] bus_addr;
    logic [15:0] bus_wdata, bus_rdata;
    logic [1:0]  bus_byteenable, sdram_ba, sdram_dqm;
    logic        bus_ready, bus_rvalid;
    logic        sdram_cke, sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n;
    logic [11:0] sdram_addr;
    wire  [15:0] sdram_dq;
    wire  [3:0]  pin_cmd;
    wire         is_cmd;

    int          cyc = 0, gap = 0, need = 0, ref_gap = 0, ref_count = 0;
    int          desl_cnt = 0, errors = 0, checks = 0;
    logic        have_prev = 1'b0;
    logic [CL+1:0] rd_hist = '0;        // READ seen on pins, by age
    logic [3:0]  init_cmds [$];
    logic [11:0] init_addr [$];
    logic [15:0] shadow [int];
    logic [23:0] pool [8];

    sdram_ctrl_top #(
        .CLK_MHZ(MHZ), .AW(24), .DW(16), .RAW(12), .CAW(9),
        .CAS_LATENCY(CL), .INIT_CYCLES(INIT_C), .REFRESH_CYCLES(REF_C)
    ) u_sdram_ctrl_top (
        .clk, .rst_n, .bus_read, .bus_write, .bus_addr, .bus_wdata, .bus_byteenable,
        .bus_ready, .bus_rvalid, .bus_rdata, .sdram_cke, .sdram_cs_n, .sdram_ras_n,
        .sdram_cas_n, .sdram_we_n, .sdram_addr, .sdram_ba, .sdram_dqm, .sdram_dq
    );

    sdram_model #(.RAW(12), .CAW(9), .DW(16), .CAS_LATENCY(CL)) u_model (
        .clk, .cke(sdram_cke), .cs_n(sdram_cs_n), .ras_n(sdram_ras_n), .cas_n(sdram_cas_n),
        .we_n(sdram_we_n), .addr(sdram_addr), .ba(sdram_ba), .dqm(sdram_dqm), .dq(sdram_dq)
    );

    always #20 clk = ~clk;

    assign pin_cmd = {sdram_cs_n, sdram_ras_n, sdram_cas_n, sdram_we_n};
    assign is_cmd  = sdram_cke && pin_cmd != CMD_NOP && pin_cmd != CMD_DESL;

    function automatic int need_of(input logic [3:0] c);
        case (c)
            CMD_PRECHARGE: return C_RP;
            CMD_REFRESH:   return C_RFC;
            CMD_LMR:       return C_MRD;
            CMD_ACTIVE:    return C_RCD;
            CMD_WRITE:     return C_WR + C_RP;   // Auto-precharge included
            CMD_READ:      return CL + C_RP;
            default:       return 0;
        endcase
    endfunction

    // ------------------------------
    // Pin monitor
    // ------------------------------
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (rst_n) begin
            rd_hist <= {rd_hist[CL:0], sdram_cke && pin_cmd == CMD_READ};
            ref_gap <= (is_cmd && pin_cmd == CMD_REFRESH) ? 1 : ref_gap + 1;
            gap     <= is_cmd ? 1 : gap + 1;
            if (is_cmd) begin
                need      <= need_of(pin_cmd);
                have_prev <= 1'b1;
                if (init_cmds.size() < 4) begin
                    init_cmds.push_back(pin_cmd);
                    init_addr.push_back(sdram_addr);
                end
            end
            if (is_cmd && pin_cmd == CMD_REFRESH) ref_count <= ref_count + 1;
            if (sdram_cke && pin_cmd == CMD_DESL && init_cmds.size() == 0) desl_cnt <= desl_cnt + 1;
        end
    end

    task automatic report_fail(input string what);
        errors++;
        $display("FAIL t=%0t %s", $time, what);
    endtask

    a_reset_idle: assert property (@(posedge clk) (!rst_n && cyc > 0) |->
        (!bus_ready && !bus_rvalid && !sdram_cke && pin_cmd == 4'b1111 &&
         !u_sdram_ctrl_top.u_pin_reg.dq_en))
        else report_fail("outputs not inactive during reset");
    a_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        (is_cmd && have_prev) |-> gap >= need)
        else report_fail("command spacing cut short");
    a_col_a10: assert property (@(posedge clk) disable iff (!rst_n)
        (is_cmd && pin_cmd inside {CMD_READ, CMD_WRITE}) |-> sdram_addr[10])
        else report_fail("READ or WRITE without auto-precharge");
    a_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rvalid == rd_hist[CL+1])
        else begin
            errors++;
            $display("MISMATCH t=%0t bus_rvalid got %b exp %b", $time, bus_rvalid, rd_hist[CL+1]);
        end
    // Open interval counts too, so a refresh that never comes is caught
    a_ref_gap: assert property (@(posedge clk) disable iff (!rst_n)
        ref_gap <= REF_C + ACC_LEN)
        else report_fail("refresh interval too long");

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!bus_ready && n < LIMIT) begin
            tick();
            n++;
        end
        if (!bus_ready) report_fail("timeout waiting for bus_ready");
    endtask

    // Request held until bus_ready, then taken on the next edge
    task automatic issue(input logic rd, input logic [23:0] a, input logic [15:0] d,
                         input logic [1:0] be);
        bus_read       = rd;
        bus_write      = !rd;
        bus_addr       = a;
        bus_wdata      = d;
        bus_byteenable = be;
        wait_ready();
        tick();
        bus_read  = 1'b0;
        bus_write = 1'b0;
    endtask

    task automatic write_word(input logic [23:0] a, input logic [15:0] d, input logic [1:0] be);
        logic [15:0] w;
        w = shadow.exists(int'(a >> 1)) ? shadow[int'(a >> 1)] : 16'h0;
        for (int b = 0; b < 2; b++) begin
            if (be[b]) w[b*8 +: 8] = d[b*8 +: 8];   // Byte-wise merge
        end
        shadow[int'(a >> 1)] = w;
        issue(1'b0, a, d, be);
    endtask

    task automatic read_check(input logic [23:0] a);
        int n;
        n = 0;
        issue(1'b1, a, 16'h0, 2'b11);
        while (!bus_rvalid && n < LIMIT) begin
            tick();
            n++;
        end
        if (!bus_rvalid) report_fail("timeout waiting for bus_rvalid");
        else check_eq("bus_rdata", bus_rdata, shadow[int'(a >> 1)]);
    endtask

    task automatic end_test(input int num, input string name);
        $display("Test %0d %s finished, errors %0d", num, name, errors);
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        int r0, n, idx;
        logic [3:0] exp_seq [4];
        void'($urandom(32'he708));
        exp_seq = '{CMD_PRECHARGE, CMD_REFRESH, CMD_REFRESH, CMD_LMR};
        rst_n = 1'b0;
        bus_read = 1'b0;
        bus_write = 1'b0;
        bus_addr = '0;
        bus_wdata = '0;
        bus_byteenable = '0;
        repeat (8) @(posedge clk);
        #2 rst_n = 1'b1;

        wait_ready();                   // Init sequence
        check_eq("desl_cycles", desl_cnt, INIT_C);
        check_eq("init_cmd_count", init_cmds.size(), 4);
        for (int i = 0; i < 4 && i < init_cmds.size(); i++) begin
            check_eq("init_cmd", init_cmds[i], exp_seq[i]);
        end
        if (init_cmds.size() == 4) begin
            check_eq("precharge_a10", init_addr[0][10], 1);
            check_eq("lmr_addr", init_addr[3], CL << 4);   // BL1, sequential
        end
        end_test(1, "reset and init");

        write_word(24'h01_2344, 16'hbeef, 2'b11);
        read_check(24'h01_2344);
        end_test(2, "write then read");

        write_word(24'h20_0a10, 16'h1234, 2'b11);
        write_word(24'h20_0a10, 16'hab77, 2'b10);  // Low byte stays 34
        read_check(24'h20_0a10);
        end_test(3, "byte-enable merge");

        for (int i = 0; i < 8; i++) begin        // Same column, all banks, two rows
            write_word(24'((i % 4) << 22) | 24'((i / 4) << 10) | 24'h00_0102,
                       16'(16'h1111 * (i + 1)), 2'b11);
        end
        for (int i = 0; i < 8; i++) begin        // Bank or row aliasing shows here
            read_check(24'((i % 4) << 22) | 24'((i / 4) << 10) | 24'h00_0102);
        end
        end_test(4, "command spacing");

        for (int i = 0; i < 3; i++) begin
            r0 = ref_count;
            n  = 0;
            while (ref_count == r0 && n < LIMIT) begin
                tick();
                n++;
            end
            if (ref_count == r0) report_fail("no refresh seen");
            write_word(24'h31_0040 + 24'(i * 2), 16'(16'hc3a0 + i), 2'b11);  // Raised mid-refresh
            read_check(24'h31_0040 + 24'(i * 2));
        end
        end_test(5, "refresh interval");

        for (int i = 0; i < 8; i++) begin
            pool[i] = 24'($urandom) & 24'hff_fffe;
            write_word(pool[i], 16'($urandom), 2'b11);
        end
        for (int i = 0; i < 40; i++) begin
            idx = int'($urandom % 8);
            if ($urandom % 2) write_word(pool[idx], 16'($urandom), 2'($urandom));
            else read_check(pool[idx]);
        end
        end_test(6, "random traffic");

        tick();
        $display("Summary: 6 tests, %0d data checks, %0d errors", checks, errors);
        if (errors == 0) $display("All checks passed");
        else $display("Checks failed");
        $finish;
    end

    // Watchdog over all six tests
    initial begin
        #(6 * BUDGET * 40);
        $display("Watchdog expired after %0d cycles, tests did not finish", 6 * BUDGET);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire
